// ==== hw/iq_select_pkg.sv ====
`default_nettype none

package iq_select_pkg;

	parameter int NUM_ENTRIES = 7; // entries per queue.
	parameter int TAG_W = 5; // physical register tag.
	parameter int IDX_W = 3; // entry index.

	// ********************
	// queue entry control word
	// ********************
	// The same 21 bits come out of the ALU and LS queues.
	typedef struct packed {
		logic [TAG_W-1:0] src2_tag;
		logic src2_wait; // src2 waits on a producer tag.
		logic src2_rdy;
		logic [TAG_W-1:0] src1_tag;
		logic src1_wait;
		logic src1_rdy;
		logic [TAG_W-1:0] dst_tag;
		logic src1_none; // src1 unused, immediate.
		logic issued;
	} iq_entry_t;

	// ********************
	// select result
	// ********************
	typedef struct packed {
		logic valid;
		logic [IDX_W-1:0] idx;
		logic [TAG_W-1:0] tag; // dst tag of the picked entry.
	} grant_t;

endpackage

`default_nettype wire

// ==== hw/wakeup_match.sv ====
`timescale 1ns/1ps
`default_nettype none

module wakeup_match #(
	parameter int NUM_ENTRIES = iq_select_pkg::NUM_ENTRIES
)(
	input wire iq_select_pkg::iq_entry_t entries [NUM_ENTRIES],
	input wire iq_select_pkg::grant_t bcast0,
	input wire iq_select_pkg::grant_t bcast1,
	output logic [NUM_ENTRIES-1:0] ready,
	output logic [1:0] wakeup [NUM_ENTRIES]
);
	import iq_select_pkg::*;

	// an invalid grant never matches, even on tag zero.
	function automatic logic tag_hit(
		input logic [TAG_W-1:0] tag,
		input grant_t b0,
		input grant_t b1
	);
		return (b0.valid && (tag == b0.tag)) || (b1.valid && (tag == b1.tag));
	endfunction

	// ********************
	// readiness
	// ********************
	always_comb begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			ready[i] = !entries[i].issued && entries[i].src2_rdy
				&& (entries[i].src1_rdy || entries[i].src1_none);
		end
	end

	// ********************
	// operand wakeup
	// ********************
	// Kept apart from the ready vector, which feeds the picker that drives bcast.
	always_comb begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			wakeup[i][1] = entries[i].src2_rdy || entries[i].issued
				|| (entries[i].src2_wait && tag_hit(entries[i].src2_tag, bcast0, bcast1));
			wakeup[i][0] = entries[i].src1_rdy || entries[i].src1_none || entries[i].issued
				|| (entries[i].src1_wait && tag_hit(entries[i].src1_tag, bcast0, bcast1));
		end
	end

endmodule

`default_nettype wire

// ==== hw/pick_one.sv ====
`timescale 1ns/1ps
`default_nettype none

module pick_one #(
	parameter int NUM_ENTRIES = iq_select_pkg::NUM_ENTRIES
)(
	input wire iq_select_pkg::iq_entry_t entries [NUM_ENTRIES],
	input wire [NUM_ENTRIES-1:0] ready,
	output iq_select_pkg::grant_t grant
);
	import iq_select_pkg::*;

	// ********************
	// priority scan
	// ********************
	// Walk from the top down, so the lowest ready index is written last.
	always_comb begin
		grant = '0; // no ready entry, all zero.
		for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
			if (ready[i]) begin
				grant.valid = 1'b1;
				grant.idx = IDX_W'(i);
				grant.tag = entries[i].dst_tag; // tag mux.
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/pick_two.sv ====
`timescale 1ns/1ps
`default_nettype none

module pick_two #(
	parameter int NUM_ENTRIES = iq_select_pkg::NUM_ENTRIES
)(
	input wire iq_select_pkg::iq_entry_t entries [NUM_ENTRIES],
	input wire [NUM_ENTRIES-1:0] ready,
	output iq_select_pkg::grant_t grant0,
	output iq_select_pkg::grant_t grant1
);

	logic [NUM_ENTRIES-1:0] ready_hi; // entries above grant0.

	pick_one #(
		.NUM_ENTRIES(NUM_ENTRIES)
	) u_pick0 (
		.entries(entries),
		.ready(ready),
		.grant(grant0)
	);

	// ********************
	// mask for the second pick
	// ********************
	always_comb begin
		ready_hi = ready;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (grant0.valid && (i <= int'(grant0.idx))) begin
				ready_hi[i] = 1'b0;
			end
		end
	end

	pick_one #(
		.NUM_ENTRIES(NUM_ENTRIES)
	) u_pick1 (
		.entries(entries),
		.ready(ready_hi),
		.grant(grant1)
	);

	always_comb begin
		if (grant0.valid && grant1.valid) begin
			assert final (grant0.idx < grant1.idx)
				else $error("pick_two: grants out of order %0d, %0d.", grant0.idx, grant1.idx);
		end
	end

endmodule

`default_nettype wire

// ==== hw/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input wire clk,
	input wire rst,
	input wire iq_select_pkg::grant_t alu_pick0,
	input wire iq_select_pkg::grant_t alu_pick1,
	input wire iq_select_pkg::grant_t ls_pick,
	output iq_select_pkg::grant_t alu_issue0,
	output iq_select_pkg::grant_t alu_issue1,
	output iq_select_pkg::grant_t ls_issue
);

	// ********************
	// issue registers
	// ********************
	// One set of selections in flight, no stall.
	always_ff @(posedge clk) begin
		if (rst) begin
			alu_issue0 <= '0;
			alu_issue1 <= '0;
			ls_issue <= '0;
		end else begin
			alu_issue0 <= alu_pick0;
			alu_issue1 <= alu_pick1; // second alu port.
			ls_issue <= ls_pick;
		end
	end

	// ********************
	// checks
	// ********************
	// ALU port 1 only fires alongside port 0.
	a_alu_order: assert property (
		@(posedge clk) alu_issue1.valid |-> alu_issue0.valid
	) else $error("issue_stage: alu_issue1 valid without alu_issue0.");

	// ALU ports carry distinct entries in ascending order.
	a_alu_idx: assert property (
		@(posedge clk) (alu_issue0.valid && alu_issue1.valid)
			|-> (alu_issue0.idx < alu_issue1.idx)
	) else $error("issue_stage: alu issue indices %0d, %0d out of order.",
		alu_issue0.idx, alu_issue1.idx);

endmodule

`default_nettype wire

// ==== hw/iq_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module iq_select #(
	parameter int NUM_ENTRIES = iq_select_pkg::NUM_ENTRIES
)(
	input wire clk,
	input wire rst,
	input wire iq_select_pkg::iq_entry_t alu_entries [NUM_ENTRIES],
	input wire iq_select_pkg::iq_entry_t ls_entries [NUM_ENTRIES],
	output logic [1:0] alu_wakeup [NUM_ENTRIES],
	output logic [1:0] ls_wakeup [NUM_ENTRIES],
	output iq_select_pkg::grant_t alu_issue0,
	output iq_select_pkg::grant_t alu_issue1,
	output iq_select_pkg::grant_t ls_issue
);
	import iq_select_pkg::*;

	logic [NUM_ENTRIES-1:0] alu_ready;
	logic [NUM_ENTRIES-1:0] ls_ready;

	grant_t alu_pick0; // also wakeup broadcast 0.
	grant_t alu_pick1; // also wakeup broadcast 1.
	grant_t ls_pick;

	// ********************
	// ALU queue
	// ********************
	wakeup_match #(
		.NUM_ENTRIES(NUM_ENTRIES)
	) u_alu_wake (
		.entries(alu_entries),
		.bcast0(alu_pick0),
		.bcast1(alu_pick1),
		.ready(alu_ready),
		.wakeup(alu_wakeup)
	);

	pick_two #(
		.NUM_ENTRIES(NUM_ENTRIES)
	) u_alu_pick (
		.entries(alu_entries),
		.ready(alu_ready),
		.grant0(alu_pick0),
		.grant1(alu_pick1)
	);

	// ********************
	// LS queue
	// ********************
	// Only ALU results wake operands, in this queue as well.
	wakeup_match #(
		.NUM_ENTRIES(NUM_ENTRIES)
	) u_ls_wake (
		.entries(ls_entries),
		.bcast0(alu_pick0),
		.bcast1(alu_pick1),
		.ready(ls_ready),
		.wakeup(ls_wakeup)
	);

	pick_one #(
		.NUM_ENTRIES(NUM_ENTRIES)
	) u_ls_pick (
		.entries(ls_entries),
		.ready(ls_ready),
		.grant(ls_pick)
	);

	issue_stage u_issue (
		.clk(clk),
		.rst(rst),
		.alu_pick0(alu_pick0),
		.alu_pick1(alu_pick1),
		.ls_pick(ls_pick),
		.alu_issue0(alu_issue0),
		.alu_issue1(alu_issue1),
		.ls_issue(ls_issue)
	);

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RST_CYCLES = 5
)(
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0; // released between sampling edges.
	end

endmodule

`default_nettype wire

// ==== dv/iq_select_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module iq_select_checker #(
	parameter int NUM_ENTRIES = iq_select_pkg::NUM_ENTRIES
)(
	input wire clk,
	input wire rst,
	input wire [1:0] alu_wakeup [NUM_ENTRIES],
	input wire [1:0] ls_wakeup [NUM_ENTRIES],
	input wire iq_select_pkg::grant_t alu_issue0,
	input wire iq_select_pkg::grant_t alu_issue1,
	input wire iq_select_pkg::grant_t ls_issue,
	input wire [1:0] exp_alu_wake [NUM_ENTRIES],
	input wire [1:0] exp_ls_wake [NUM_ENTRIES],
	input wire iq_select_pkg::grant_t exp_alu0,
	input wire iq_select_pkg::grant_t exp_alu1,
	input wire iq_select_pkg::grant_t exp_ls,
	output int error_count,
	output int check_count
);
	import iq_select_pkg::*;

	grant_t held_alu0; // expected issue, one edge old.
	grant_t held_alu1;
	grant_t held_ls;
	bit primed = 1'b0;
	int checks = 0;
	int errors = 0;
	int mark_checks = 0;
	int mark_errors = 0;

	assign error_count = errors;
	assign check_count = checks;

	task automatic compare(input string what, input logic [8:0] got, input logic [8:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// ********************
	// sampling
	// ********************
	always @(posedge clk) begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			compare($sformatf("alu_wakeup[%0d]", i), 9'(alu_wakeup[i]), 9'(exp_alu_wake[i]));
			compare($sformatf("ls_wakeup[%0d]", i), 9'(ls_wakeup[i]), 9'(exp_ls_wake[i]));
		end
		if (primed) begin
			compare("alu_issue0", alu_issue0, held_alu0);
			compare("alu_issue1", alu_issue1, held_alu1);
			compare("ls_issue", ls_issue, held_ls);
		end
		held_alu0 = rst ? '0 : exp_alu0; // registers clear under reset.
		held_alu1 = rst ? '0 : exp_alu1;
		held_ls = rst ? '0 : exp_ls;
		primed = 1'b1;
	end

	task automatic report_test(input string name);
		$display("test %s: %0d checks, %0d errors", name,
			checks - mark_checks, errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	task automatic report_totals();
		$display("total: %0d checks, %0d errors", checks, errors);
	endtask

endmodule

`default_nettype wire

// ==== dv/iq_select_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module iq_select_tb #(
	parameter int NUM_ENTRIES = iq_select_pkg::NUM_ENTRIES
);
	import iq_select_pkg::*;

	logic clk;
	logic rst;
	iq_entry_t alu_entries [NUM_ENTRIES];
	iq_entry_t ls_entries [NUM_ENTRIES];
	logic [1:0] alu_wakeup [NUM_ENTRIES];
	logic [1:0] ls_wakeup [NUM_ENTRIES];
	grant_t alu_issue0;
	grant_t alu_issue1;
	grant_t ls_issue;
	logic [1:0] exp_alu_wake [NUM_ENTRIES];
	logic [1:0] exp_ls_wake [NUM_ENTRIES];
	grant_t exp_alu0;
	grant_t exp_alu1;
	grant_t exp_ls;
	int error_count;
	int check_count;
	bit released;

	tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(5)) u_clk (.clk(clk), .rst(rst));

	iq_select #(.NUM_ENTRIES(NUM_ENTRIES)) UUT (.*);

	iq_select_checker #(.NUM_ENTRIES(NUM_ENTRIES)) u_chk (.*);

	// ********************
	// reference model
	// ********************
	function automatic logic is_ready(input iq_entry_t e);
		return !e.issued && e.src2_rdy && (e.src1_rdy || e.src1_none);
	endfunction

	function automatic grant_t pick_lowest(input iq_entry_t q [NUM_ENTRIES], input int after);
		grant_t g;
		g = '0;
		for (int i = after + 1; i < NUM_ENTRIES; i++) begin
			if (!g.valid && is_ready(q[i])) begin
				g.valid = 1'b1;
				g.idx = IDX_W'(i);
				g.tag = q[i].dst_tag;
			end
		end
		return g;
	endfunction

	function automatic logic [1:0] wake_bits(input iq_entry_t e, input grant_t b0,
		input grant_t b1);
		logic hit2;
		logic hit1;
		hit2 = e.src2_wait && ((b0.valid && b0.tag == e.src2_tag)
			|| (b1.valid && b1.tag == e.src2_tag));
		hit1 = e.src1_wait && ((b0.valid && b0.tag == e.src1_tag)
			|| (b1.valid && b1.tag == e.src1_tag));
		return {e.issued || e.src2_rdy || hit2, e.issued || e.src1_rdy || e.src1_none || hit1};
	endfunction

	always_comb begin
		exp_alu0 = pick_lowest(alu_entries, -1);
		exp_alu1 = exp_alu0.valid ? pick_lowest(alu_entries, int'(exp_alu0.idx)) : '0;
		exp_ls = pick_lowest(ls_entries, -1);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			exp_alu_wake[i] = wake_bits(alu_entries[i], exp_alu0, exp_alu1);
			exp_ls_wake[i] = wake_bits(ls_entries[i], exp_alu0, exp_alu1);
		end
	end

	// ********************
	// stimulus helpers
	// ********************
	function automatic iq_entry_t ready_entry(input logic [TAG_W-1:0] dst);
		iq_entry_t e;
		e = '0;
		e.src2_rdy = 1'b1;
		e.src1_rdy = 1'b1;
		e.dst_tag = dst;
		return e;
	endfunction

	function automatic iq_entry_t waiting_entry(input logic [TAG_W-1:0] t2,
		input logic [TAG_W-1:0] t1);
		iq_entry_t e;
		e = '0;
		e.src2_wait = 1'b1;
		e.src2_tag = t2;
		e.src1_wait = 1'b1;
		e.src1_tag = t1;
		return e;
	endfunction

	function automatic iq_entry_t random_entry();
		iq_entry_t e;
		e.src2_tag = 5'($urandom_range(0, 7)); // narrow tags, more matches.
		e.src2_wait = 1'($urandom);
		e.src2_rdy = 1'($urandom);
		e.src1_tag = 5'($urandom_range(0, 7));
		e.src1_wait = 1'($urandom);
		e.src1_rdy = 1'($urandom);
		e.dst_tag = 5'($urandom_range(0, 7));
		e.src1_none = ($urandom_range(0, 3) == 0);
		e.issued = ($urandom_range(0, 3) == 0);
		return e;
	endfunction

	task automatic clear_entries();
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			alu_entries[i] = '0;
			ls_entries[i] = '0;
		end
	endtask

	task automatic cycles(input int n);
		for (int k = 0; k < n; k++) @(negedge clk);
	endtask

	task automatic wait_reset(output bit ok);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (rst && n < 50);
		ok = !rst;
		if (!ok) $display("timeout: reset still asserted after %0d cycles", n);
	endtask

	// ********************
	// test sequence
	// ********************
	initial begin
		void'($urandom(32));
		clear_entries();
		alu_entries[0] = ready_entry(5'd3); // ready all through reset.
		ls_entries[1] = ready_entry(5'd4);
		wait_reset(released);
		if (released) begin
			cycles(2);
			u_chk.report_test("reset");
			clear_entries();
			alu_entries[2] = ready_entry(5'd6);
			alu_entries[2].issued = 1'b1;
			cycles(2);
			alu_entries[3] = ready_entry(5'd9);
			cycles(2);
			u_chk.report_test("single_ready");
			clear_entries();
			alu_entries[1] = ready_entry(5'd11);
			alu_entries[2] = ready_entry(5'd12);
			alu_entries[2].issued = 1'b1;
			alu_entries[4] = ready_entry(5'd14);
			alu_entries[5] = ready_entry(5'd15);
			ls_entries[0] = ready_entry(5'd20);
			ls_entries[0].issued = 1'b1;
			ls_entries[2] = ready_entry(5'd21);
			ls_entries[5] = ready_entry(5'd22);
			cycles(2);
			u_chk.report_test("multi_ready");
			clear_entries();
			alu_entries[0] = ready_entry(5'd7);
			alu_entries[1] = ready_entry(5'd12);
			alu_entries[3] = waiting_entry(5'd7, 5'd12);
			ls_entries[2] = waiting_entry(5'd12, 5'd20);
			cycles(2);
			alu_entries[1] = '0; // second grant now invalid with tag 0.
			alu_entries[3] = waiting_entry(5'd0, 5'd7);
			ls_entries[2] = waiting_entry(5'd0, 5'd0);
			cycles(2);
			u_chk.report_test("wakeup");
			for (int c = 0; c < 300; c++) begin
				for (int i = 0; i < NUM_ENTRIES; i++) begin
					alu_entries[i] = random_entry();
					ls_entries[i] = random_entry();
				end
				cycles(1);
			end
			cycles(1);
			u_chk.report_test("random");
		end
		u_chk.report_totals();
		if (released && error_count == 0 && check_count > 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== iq_select.f ====
hw/iq_select_pkg.sv
hw/wakeup_match.sv
hw/pick_one.sv
hw/pick_two.sv
hw/issue_stage.sv
hw/iq_select.sv
dv/tb_clk_gen.sv
dv/iq_select_checker.sv
dv/iq_select_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= iq_select_tb
FILELIST ?= iq_select.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
